// ==== include/axilwr2wb_macros.svh ====
// Bus widths and write pipeline depth for the AXI-lite write to Wishbone bridge
`ifndef AXILWR2WB_MACROS_SVH
`define AXILWR2WB_MACROS_SVH

// AXI-lite side, byte addressed
`define AXILWR2WB_ADDR_WIDTH 28
`define AXILWR2WB_DATA_WIDTH 32
`define AXILWR2WB_SEL_WIDTH (`AXILWR2WB_DATA_WIDTH / 8)

// Byte offset bits below the word address
`define AXILWR2WB_ADDR_LSBS 2

// Wishbone side, word addressed
`define AXILWR2WB_WB_ADDR_WIDTH (`AXILWR2WB_ADDR_WIDTH - `AXILWR2WB_ADDR_LSBS)

// Up to 2**LGFIFO writes between acceptance and response
`define AXILWR2WB_LGFIFO 3

`endif

// ==== verilog/axilwr2wb_pkg.sv ====
// Payload, response and pointer types shared across the AXI-lite write bridge
`include "axilwr2wb_macros.svh"

package axilwr2wb_pkg;

	// Write address channel item
	typedef struct packed {
		logic [`AXILWR2WB_ADDR_WIDTH-1:0] addr;
	} axil_aw_t;

	// Write data channel item
	typedef struct packed {
		logic [`AXILWR2WB_DATA_WIDTH-1:0] data;
		logic [`AXILWR2WB_SEL_WIDTH-1:0]  strb;
	} axil_w_t;

	// One Wishbone write request, word addressed
	typedef struct packed {
		logic [`AXILWR2WB_WB_ADDR_WIDTH-1:0] addr;
		logic [`AXILWR2WB_DATA_WIDTH-1:0]    data;
		logic [`AXILWR2WB_SEL_WIDTH-1:0]     sel;
	} wb_req_t;

	typedef enum logic [1:0] {
		BRESP_OKAY   = 2'b00,
		BRESP_SLVERR = 2'b10,
		BRESP_DECERR = 2'b11
	} bresp_t;

	// Extra top bit tells full from empty
	typedef logic [`AXILWR2WB_LGFIFO:0] txn_ptr_t;

endpackage

// ==== verilog/axil_channel_slot.sv ====
// Single-entry holding slot that lets one AXI channel run ahead of the other
`timescale 1ns/100ps

module axil_channel_slot #(
	parameter type payload_t = axilwr2wb_pkg::axil_aw_t
) (
	input  logic     i_clk,
	input  logic     w_reset,
	input  logic     i_valid,
	input  payload_t i_payload,
	output logic     o_ready,
	output logic     o_avail,
	output payload_t o_payload,
	input  logic     i_take
);
	import axilwr2wb_pkg::*;

	logic     held_valid;
	payload_t held;

	// Ready only while nothing is parked here
	assign o_ready   = !held_valid;
	assign o_avail   = held_valid || i_valid;
	assign o_payload = held_valid ? held : i_payload;

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			held_valid <= 1'b0;
		else if (i_take)
			held_valid <= 1'b0;
		else if (i_valid && o_ready)
			held_valid <= 1'b1;
	end

	// Capture only when the item is not passed straight through
	always_ff @(posedge i_clk)
	begin
		if (!held_valid && i_valid && !i_take)
			held <= i_payload;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_held_stable: assert property (@(posedge i_clk) disable iff (w_reset)
		held_valid && !i_take |=> held_valid && $stable(held));

endmodule

// ==== verilog/wb_write_issuer.sv ====
// Wishbone pipelined write master with strobe, request register and ack counter
`timescale 1ns/100ps
`include "axilwr2wb_macros.svh"

module wb_write_issuer (
	input  logic                  i_clk,
	input  logic                  w_reset,
	input  logic                  i_accept,
	input  axilwr2wb_pkg::wb_req_t i_req,
	output logic                  o_issue_free,
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output axilwr2wb_pkg::wb_req_t o_wb_req,
	input  logic                  i_wb_ack,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_err,
	output logic                  o_done_ok,
	output logic                  o_done_err
);
	import axilwr2wb_pkg::*;

	localparam int LGFIFO = `AXILWR2WB_LGFIFO;
	localparam int DEPTH  = 1 << LGFIFO;

	logic              stb;
	wb_req_t           req_q;
	logic [LGFIFO:0]   outstanding;
	logic              stb_taken;

	assign o_wb_stb  = stb;
	assign o_wb_req  = req_q;
	assign stb_taken = stb && !i_wb_stall;

	// A new write may load when the current strobe goes out this cycle
	assign o_issue_free = !stb || !i_wb_stall;
	assign o_wb_cyc     = stb || (outstanding != '0);

	// Responses outside a cycle are ignored
	assign o_done_ok  = o_wb_cyc && i_wb_ack;
	assign o_done_err = o_wb_cyc && i_wb_err;

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			stb <= 1'b0;
		else if (o_done_err)
			stb <= 1'b0;
		else if (i_accept)
			stb <= 1'b1;
		else if (!i_wb_stall)
			stb <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_accept)
			req_q <= i_req;
	end

	////////////////////////////////////////////////////////////////////////////
	// Outstanding acknowledgements
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset || o_done_err)
			outstanding <= '0;
		else
		begin
			case ({stb_taken, o_done_ok})
			2'b10: outstanding <= outstanding + 1'b1;
			2'b01: outstanding <= outstanding - 1'b1;
			default: outstanding <= outstanding;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge i_clk) disable iff (w_reset)
		outstanding <= DEPTH);

	// A stalled request must be presented unchanged
	a_stall_hold: assert property (@(posedge i_clk) disable iff (w_reset)
		stb && i_wb_stall && !o_done_err |=> stb && $stable(req_q));

endmodule

// ==== verilog/write_txn_tracker.sv ====
// Write acceptance, in-order completion tracking, error flush and AXI response
`timescale 1ns/100ps
`include "axilwr2wb_macros.svh"

module write_txn_tracker (
	input  logic                  i_clk,
	input  logic                  w_reset,
	input  logic                  i_aw_avail,
	input  logic                  i_w_avail,
	input  logic                  i_issue_free,
	output logic                  o_accept,
	input  logic                  i_done_ok,
	input  logic                  i_done_err,
	output logic                  o_axi_bvalid,
	output axilwr2wb_pkg::bresp_t o_axi_bresp,
	input  logic                  i_axi_bready
);
	import axilwr2wb_pkg::*;

	localparam int LGFIFO = `AXILWR2WB_LGFIFO;
	localparam int DEPTH  = 1 << LGFIFO;

	// first: accepted, mid: completed, last: answered
	txn_ptr_t first;
	txn_ptr_t mid;
	txn_ptr_t last;
	txn_ptr_t fill;

	logic   err_state;
	logic   fifo_full;
	logic   done;
	logic   flush_step;
	logic   resp_take;
	bresp_t results [DEPTH];

	assign fill       = first - last;
	assign fifo_full  = fill[LGFIFO];
	assign done       = i_done_ok || i_done_err;
	assign flush_step = err_state && (mid != first);
	assign resp_take  = o_axi_bvalid && i_axi_bready;

	assign o_accept = i_aw_avail && i_w_avail && i_issue_free
		&& !fifo_full && !err_state;

	assign o_axi_bvalid = (mid != last);
	assign o_axi_bresp  = results[last[LGFIFO-1:0]];

	////////////////////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			first <= '0;
		else if (o_accept)
			first <= first + 1'b1;
	end

	// Flush steps only run once the bus cycle has been dropped
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			mid <= '0;
		else if (done || flush_step)
			mid <= mid + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			last <= '0;
		else if (resp_take)
			last <= last + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			err_state <= 1'b0;
		else if (i_done_err)
			err_state <= 1'b1;
		else if (first == last)
			err_state <= 1'b0;
	end

	// Result per write, read back in order at last
	always_ff @(posedge i_clk)
	begin
		if (done)
			results[mid[LGFIFO-1:0]] <= i_done_err ? BRESP_SLVERR : BRESP_OKAY;
		else if (flush_step)
			results[mid[LGFIFO-1:0]] <= BRESP_DECERR;
	end

	a_fill_bound: assert property (@(posedge i_clk) disable iff (w_reset)
		fill <= DEPTH);

	// Nothing enters the pipeline while the error is being drained
	a_no_accept_err: assert property (@(posedge i_clk) disable iff (w_reset)
		err_state |=> first == $past(first));

endmodule

// ==== verilog/axilwr2wb_bridge.sv ====
// AXI-lite write slave to pipelined Wishbone write master bridge, top level
`timescale 1ns/100ps
`include "axilwr2wb_macros.svh"

module axilwr2wb_bridge (
	input  logic                                i_clk,
	input  logic                                i_axi_reset_n,
	// AXI write address channel
	input  logic                                i_axi_awvalid,
	input  logic [`AXILWR2WB_ADDR_WIDTH-1:0]    i_axi_awaddr,
	output logic                                o_axi_awready,
	// AXI write data channel
	input  logic                                i_axi_wvalid,
	input  logic [`AXILWR2WB_DATA_WIDTH-1:0]    i_axi_wdata,
	input  logic [`AXILWR2WB_SEL_WIDTH-1:0]     i_axi_wstrb,
	output logic                                o_axi_wready,
	// AXI write response channel
	output logic                                o_axi_bvalid,
	output logic [1:0]                          o_axi_bresp,
	input  logic                                i_axi_bready,
	// Wishbone pipelined master
	output logic                                o_wb_cyc,
	output logic                                o_wb_stb,
	output logic [`AXILWR2WB_WB_ADDR_WIDTH-1:0] o_wb_addr,
	output logic [`AXILWR2WB_DATA_WIDTH-1:0]    o_wb_data,
	output logic [`AXILWR2WB_SEL_WIDTH-1:0]     o_wb_sel,
	input  logic                                i_wb_ack,
	input  logic                                i_wb_stall,
	input  logic                                i_wb_err
);
	import axilwr2wb_pkg::*;

	logic      w_reset;
	axil_aw_t  aw_in;
	axil_aw_t  aw_payload;
	axil_w_t   w_in;
	axil_w_t   w_payload;
	wb_req_t   wb_req;
	wb_req_t   wb_req_q;
	bresp_t    bresp;
	logic      aw_avail;
	logic      w_avail;
	logic      accept;
	logic      issue_free;
	logic      done_ok;
	logic      done_err;

	assign w_reset = !i_axi_reset_n;

	assign aw_in = '{addr: i_axi_awaddr};
	assign w_in  = '{data: i_axi_wdata, strb: i_axi_wstrb};

	// Word address from the byte address
	assign wb_req = '{
		addr: aw_payload.addr[`AXILWR2WB_ADDR_WIDTH-1:`AXILWR2WB_ADDR_LSBS],
		data: w_payload.data,
		sel:  w_payload.strb
	};

	assign o_wb_addr   = wb_req_q.addr;
	assign o_wb_data   = wb_req_q.data;
	assign o_wb_sel    = wb_req_q.sel;
	assign o_axi_bresp = bresp;

	axil_channel_slot #(.payload_t(axil_aw_t)) aw_slot_inst (
		.i_clk(i_clk), .w_reset(w_reset),
		.i_valid(i_axi_awvalid), .i_payload(aw_in), .o_ready(o_axi_awready),
		.o_avail(aw_avail), .o_payload(aw_payload), .i_take(accept)
	);

	axil_channel_slot #(.payload_t(axil_w_t)) w_slot_inst (
		.i_clk(i_clk), .w_reset(w_reset),
		.i_valid(i_axi_wvalid), .i_payload(w_in), .o_ready(o_axi_wready),
		.o_avail(w_avail), .o_payload(w_payload), .i_take(accept)
	);

	wb_write_issuer wb_write_issuer_inst (
		.i_clk(i_clk), .w_reset(w_reset),
		.i_accept(accept), .i_req(wb_req), .o_issue_free(issue_free),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_req(wb_req_q),
		.i_wb_ack(i_wb_ack), .i_wb_stall(i_wb_stall), .i_wb_err(i_wb_err),
		.o_done_ok(done_ok), .o_done_err(done_err)
	);

	write_txn_tracker write_txn_tracker_inst (
		.i_clk(i_clk), .w_reset(w_reset),
		.i_aw_avail(aw_avail), .i_w_avail(w_avail), .i_issue_free(issue_free),
		.o_accept(accept), .i_done_ok(done_ok), .i_done_err(done_err),
		.o_axi_bvalid(o_axi_bvalid), .o_axi_bresp(bresp),
		.i_axi_bready(i_axi_bready)
	);

endmodule

// ==== testbench/tb_axilwr2wb.sv ====
// Testbench for the AXI-lite write to Wishbone bridge with a random Wishbone responder
`timescale 1ns/100ps
`include "axilwr2wb_macros.svh"

module tb_axilwr2wb;
	import axilwr2wb_pkg::*;

	localparam int DEPTH      = 1 << `AXILWR2WB_LGFIFO;
	localparam int MAX_CYCLES = 4000;

	logic                                i_clk;
	logic                                i_axi_reset_n;
	logic                                i_axi_awvalid;
	logic [`AXILWR2WB_ADDR_WIDTH-1:0]    i_axi_awaddr;
	logic                                o_axi_awready;
	logic                                i_axi_wvalid;
	logic [`AXILWR2WB_DATA_WIDTH-1:0]    i_axi_wdata;
	logic [`AXILWR2WB_SEL_WIDTH-1:0]     i_axi_wstrb;
	logic                                o_axi_wready;
	logic                                o_axi_bvalid;
	logic [1:0]                          o_axi_bresp;
	logic                                i_axi_bready;
	logic                                o_wb_cyc;
	logic                                o_wb_stb;
	logic [`AXILWR2WB_WB_ADDR_WIDTH-1:0] o_wb_addr;
	logic [`AXILWR2WB_DATA_WIDTH-1:0]    o_wb_data;
	logic [`AXILWR2WB_SEL_WIDTH-1:0]     o_wb_sel;
	logic                                i_wb_ack;
	logic                                i_wb_stall;
	logic                                i_wb_err;

	// Expected traffic, filled from the AXI writes and the responder's choices
	wb_req_t exp_req[$];
	bresp_t  exp_resp[$];
	wb_req_t req_head;
	bresp_t  resp_head;

	string       test_name;
	int          err_count;
	int          test_count;
	int          cycles;
	int          n_sent;
	int          n_taken;
	int          n_resp;
	int          pend;
	logic [31:0] rng;
	logic        stall_heavy;
	logic        hold_ack;
	logic        bp_mode;
	logic        inject_err;
	logic        err_drain;

	axilwr2wb_bridge axilwr2wb_bridge_inst (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic report_mismatch(input logic [63:0] exp, input logic [63:0] act);
		$display("MISMATCH %s expected %h actual %h", test_name, exp, act);
		err_count++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR in %s: %s", test_name, what);
		err_count++;
	endtask

	initial
	begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles in %s", cycles, test_name);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Wishbone responder and response back-pressure, driven on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		rng = xorshift(rng);
		i_axi_bready = bp_mode ? (rng[10:8] == 3'b000) : 1'b1;
		if (!i_axi_reset_n)
		begin
			i_wb_stall = 1'b0;
			i_wb_ack   = 1'b0;
			i_wb_err   = 1'b0;
		end
		else if (inject_err)
		begin
			i_wb_err   = 1'b1;
			i_wb_ack   = 1'b0;
			i_wb_stall = 1'b0;
			inject_err = 1'b0;
		end
		else
		begin
			i_wb_err   = 1'b0;
			i_wb_stall = stall_heavy ? (rng[1:0] != 2'b00) : (rng[2:0] == 3'b000);
			i_wb_ack   = !hold_ack && (pend > 0) && rng[4];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Scoreboards
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		if (i_axi_reset_n)
		begin
			if (o_axi_bvalid && i_axi_bready)
			begin
				if (exp_resp.size() == 0)
					report_failure("response arrived with no write waiting for one");
				else
				begin
					resp_head = exp_resp.pop_front();
					a_resp: assert (o_axi_bresp == resp_head)
						else report_mismatch(resp_head, o_axi_bresp);
					n_resp++;
				end
				if (exp_resp.size() == 0)
					err_drain = 1'b0;
			end
			a_no_stb_flush: assert (!(err_drain && o_wb_stb))
				else report_failure("strobe issued before error responses were taken");
			if (o_wb_stb && !i_wb_stall)
			begin
				if (exp_req.size() == 0)
					report_failure("strobe issued with no AXI write behind it");
				else
				begin
					req_head = exp_req.pop_front();
					a_req: assert ({o_wb_addr, o_wb_data, o_wb_sel} == req_head)
						else report_mismatch(req_head, {o_wb_addr, o_wb_data, o_wb_sel});
				end
				pend++;
				n_taken++;
			end
			if (i_wb_ack && o_wb_cyc)
			begin
				pend--;
				exp_resp.push_back(BRESP_OKAY);
			end
			// The erroring write ends with SLVERR, the rest of the pipeline with DECERR
			if (i_wb_err && o_wb_cyc)
			begin
				exp_resp.push_back(BRESP_SLVERR);
				repeat (pend - 1)
					exp_resp.push_back(BRESP_DECERR);
				pend      = 0;
				err_drain = 1'b1;
			end
			a_fill: assert (n_taken - n_resp <= DEPTH)
				else report_failure("more writes in flight than the pipeline holds");
		end
	end

	a_bresp_hold: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_axi_bvalid && !i_axi_bready |=> o_axi_bvalid && $stable(o_axi_bresp))
		else report_failure("response changed while back-pressured");

	////////////////////////////////////////////////////////////////////////////
	// AXI master tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic send_aw(input logic [`AXILWR2WB_ADDR_WIDTH-1:0] addr);
		@(negedge i_clk);
		i_axi_awvalid = 1'b1;
		i_axi_awaddr  = addr;
		@(posedge i_clk);
		while (!o_axi_awready)
			@(posedge i_clk);
		@(negedge i_clk);
		i_axi_awvalid = 1'b0;
	endtask

	task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
		@(negedge i_clk);
		i_axi_wvalid = 1'b1;
		i_axi_wdata  = data;
		i_axi_wstrb  = strb;
		@(posedge i_clk);
		while (!o_axi_wready)
			@(posedge i_clk);
		@(negedge i_clk);
		i_axi_wvalid = 1'b0;
	endtask

	// order 0 drives both channels together, 1 address first, 2 data first
	task automatic axi_write(input int order);
		logic [27:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		addr = {n_sent[11:0], 4'h5, 12'h3a4} ^ {8'h0, n_sent[19:0]};
		data = {16'hc0de, n_sent[15:0]} ^ (n_sent << 20);
		strb = 4'hf ^ n_sent[3:0];
		exp_req.push_back('{addr: addr[27:2], data: data, sel: strb});
		n_sent++;
		case (order)
		1:
		begin
			send_aw(addr);
			repeat (2) @(negedge i_clk);
			send_w(data, strb);
		end
		2:
		begin
			send_w(data, strb);
			repeat (2) @(negedge i_clk);
			send_aw(addr);
		end
		default:
			fork
				send_aw(addr);
				send_w(data, strb);
			join
		endcase
	endtask

	task automatic wait_responses();
		while (n_resp != n_sent || err_drain)
			@(posedge i_clk);
	endtask

	task automatic finish_test();
		wait_responses();
		test_count++;
		$display("Test %s done, errors so far %0d", test_name, err_count);
	endtask

	initial
	begin
		rng = 32'h9a6718ac;
		test_name = "reset";
		{err_count, test_count, cycles, n_sent, n_taken, n_resp, pend} = '0;
		{stall_heavy, hold_ack, bp_mode, inject_err, err_drain} = '0;
		{i_axi_awvalid, i_axi_wvalid, i_wb_ack, i_wb_stall, i_wb_err} = '0;
		i_axi_awaddr  = '0;
		i_axi_wdata   = '0;
		i_axi_wstrb   = '0;
		i_axi_bready  = 1'b1;
		i_axi_reset_n = 1'b0;
		repeat (2) @(negedge i_clk);
		i_axi_reset_n = 1'b1;
		a_reset: assert (!o_wb_cyc && !o_wb_stb && !o_axi_bvalid
			&& o_axi_awready && o_axi_wready)
			else report_failure("outputs not idle after reset");
		finish_test();

		test_name = "single writes";
		repeat (4)
		begin
			axi_write(0);
			wait_responses();
		end
		finish_test();
		test_name = "address before data";
		repeat (3) axi_write(1);
		finish_test();
		test_name = "data before address";
		repeat (3) axi_write(2);
		finish_test();

		test_name   = "stalled burst";
		stall_heavy = 1'b1;
		repeat (12) axi_write(0);
		finish_test();
		stall_heavy = 1'b0;

		// Three writes sit unanswered, then the first one errors
		test_name = "error injection";
		hold_ack  = 1'b1;
		repeat (3) axi_write(0);
		while (pend != 3)
			@(posedge i_clk);
		inject_err = 1'b1;
		while (!err_drain)
			@(posedge i_clk);
		// Two more writes arrive while the error responses drain
		hold_ack = 1'b0;
		repeat (2) axi_write(0);
		finish_test();

		test_name = "response back-pressure";
		bp_mode   = 1'b1;
		repeat (12) axi_write(0);
		finish_test();
		bp_mode = 1'b0;

		$display("Tests run %0d, errors %0d", test_count, err_count);
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== axilwr2wb.f ====
+incdir+include
verilog/axilwr2wb_pkg.sv
verilog/axil_channel_slot.sv
verilog/wb_write_issuer.sv
verilog/write_txn_tracker.sv
verilog/axilwr2wb_bridge.sv
testbench/tb_axilwr2wb.sv
